// ==== bench/dbg_sva.sv ====
`timescale 1ns/1ps

module dbg_sva #(
    parameter int LINK_CREDITS = 0
) (
    input logic i_clk,
    input logic i_reset_n,
    input logic i_push,
    input logic i_full,
    input logic i_credit,
    input logic i_valid
);

    logic [15:0] shadow_credit;  // granted link credit less the bytes sent

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            shadow_credit <= 16'(LINK_CREDITS);
        end else begin
            shadow_credit <= shadow_credit + 16'(i_credit) - 16'(i_valid);
        end
    end

    // receive side may drop on full, transmit side never
    a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (LINK_CREDITS != 0) && i_push |-> !i_full)
        else $error("push into a full transmit queue");

    a_credit_underflow: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (LINK_CREDITS != 0) && i_valid |-> shadow_credit != 16'd0)
        else $error("link credit underflow");

    a_quiet_in_reset: assert property (@(posedge i_clk)
        (LINK_CREDITS != 0) && !i_reset_n |-> !i_valid)
        else $error("send strobe active during reset");

endmodule

// ==== bench/dbg_tb.sv ====
`timescale 1ns/1ps
`include "dbg_macros.svh"

module dbg_tb;

    typedef logic [7:0] byte_q_t[$];

    logic                     clk;
    logic                     reset_n;
    logic                     rx_dv;
    logic [7:0]               rx_byte;
    logic                     tx_credit;
    logic                     tx_dv;
    logic [7:0]               tx_byte;
    logic                     tx_last;
    dbg_proto_pkg::dbg_cmd_e  debug_cmd;
    logic [15:0]              debug_remaining;

    dbg_proto_pkg::tx_item_t  exp_q[$];  // reply bytes still owed by the DUT
    dbg_proto_pkg::tx_item_t  exp_item;
    dbg_mem_pkg::mem_data_t   model_mem [`DBG_MEM_DEPTH];
    logic [7:0]               model_ctrl;
    logic [7:0]               model_cmd_count;
    logic [7:0]               model_bad_count;
    logic [15:0]              lfsr;
    logic                     slow_credit;
    int                       errors;
    int                       err_mark;
    int                       tests;
    int                       sent;
    int                       granted;

    dbg_top i_dbg_top (
        .i_clk                   (clk),
        .i_reset_n               (reset_n),
        .i_rx_dv                 (rx_dv),
        .i_rx_byte               (rx_byte),
        .i_tx_credit             (tx_credit),
        .o_tx_dv                 (tx_dv),
        .o_tx_byte               (tx_byte),
        .o_tx_last               (tx_last),
        .o_debug_cmd             (debug_cmd),
        .o_debug_bytes_remaining (debug_remaining)
    );

    bind dbg_byte_queue dbg_sva #(.LINK_CREDITS(LINK_CREDITS)) i_sva (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_push       (i_push),
        .i_full       (o_full),
        .i_credit     (i_credit),
        .i_valid      (o_valid)
    );

    always #50 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // one LFSR step per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[14:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic check_byte(input string name, input dbg_mem_pkg::mem_data_t got,
                              input dbg_mem_pkg::mem_data_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_last(input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t: o_tx_last got %b expected %b", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_cmd(input dbg_proto_pkg::dbg_cmd_e got,
                             input dbg_proto_pkg::dbg_cmd_e exp);
        if (got !== exp) begin
            $display("error at %0t: o_debug_cmd got %0d expected %0d", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    // protocol reference, queues the expected reply and updates model state
    function automatic void model_command(input byte_q_t b);
        dbg_proto_pkg::tx_item_t item;
        logic [15:0] addr;
        logic [15:0] len;
        logic        known;
        known = 1'b1;
        addr = (b.size() > 2) ? {b[1], b[2]} : 16'd0;
        len  = (b.size() > 4) ? {b[3], b[4]} : 16'd0;
        case (b[0])
            dbg_proto_pkg::CMD_NOP: ;
            dbg_proto_pkg::CMD_ECHO: begin
                item = '{data: b[1], last: 1'b1};
                exp_q.push_back(item);
            end
            dbg_proto_pkg::CMD_MEM_WRITE: begin
                for (int k = 0; k < len; k++) begin
                    if (!model_ctrl[0]) begin
                        model_mem[(addr + 16'(k)) % `DBG_MEM_DEPTH] = b[5 + k];
                    end
                end
            end
            dbg_proto_pkg::CMD_MEM_READ: begin
                for (int k = 0; k < len; k++) begin
                    item.data = model_mem[(addr + 16'(k)) % `DBG_MEM_DEPTH];
                    item.last = (k == len - 1);
                    exp_q.push_back(item);
                end
            end
            dbg_proto_pkg::CMD_REG_WRITE: begin
                case (b[1])
                    8'd0: model_ctrl = b[2];
                    8'd1: model_cmd_count = 8'd0;
                    8'd2: model_bad_count = 8'd0;
                    default: ;
                endcase
            end
            dbg_proto_pkg::CMD_REG_READ: begin
                case (b[1])
                    8'd0: item.data = model_ctrl;
                    8'd1: item.data = model_cmd_count;  // excludes this read
                    8'd2: item.data = model_bad_count;
                    default: item.data = 8'h00;  // no overflow expected
                endcase
                item.last = 1'b1;
                exp_q.push_back(item);
            end
            default: begin
                known = 1'b0;
                if (model_bad_count != 8'hff) model_bad_count++;
            end
        endcase
        if (known && model_cmd_count != 8'hff) model_cmd_count++;
    endfunction

    function automatic byte_q_t build_mem_cmd(input logic [7:0] op, input logic [15:0] addr,
                                              input logic [15:0] len, input bit fill);
        byte_q_t b;
        b = {op, addr[15:8], addr[7:0], len[15:8], len[7:0]};
        if (fill) begin
            for (int k = 0; k < len; k++) begin
                b.push_back(8'(rand_bits(8)));
            end
        end
        return b;
    endfunction

    task automatic send_bytes(input byte_q_t b, input bit gaps);
        int n;
        foreach (b[k]) begin
            @(posedge clk);
            rx_dv   <= 1'b1;
            rx_byte <= b[k];
            n = gaps ? int'(rand_bits(2)) : 0;
            repeat (n) begin
                @(posedge clk);
                rx_dv <= 1'b0;
            end
        end
        @(posedge clk);
        rx_dv <= 1'b0;
    endtask

    // idle means nothing owed and the engine back in NOP for a few cycles
    task automatic wait_done(input int limit);
        int n;
        int quiet;
        n = 0;
        quiet = 0;
        while (quiet < 4) begin
            @(posedge clk);
            n++;
            if (exp_q.size() == 0 && debug_cmd == dbg_proto_pkg::CMD_NOP) quiet++;
            else quiet = 0;
            if (n > limit) begin
                $display("timeout: command did not complete within %0d cycles", limit);
                $display("TESTBENCH FAILED");
                $finish;
            end
        end
    endtask

    // slow consumer keeps granting until the link is back to its starting credit
    task automatic wait_link_credit(input int limit);
        int n;
        n = 0;
        while (granted < sent) begin
            @(posedge clk);
            n++;
            if (n > limit) begin
                $display("timeout: link credit not restored within %0d cycles", limit);
                $display("TESTBENCH FAILED");
                $finish;
            end
        end
    endtask

    task automatic run_cmd(input byte_q_t b, input bit gaps);
        model_command(b);
        send_bytes(b, gaps);
        wait_done(3000);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    always @(posedge clk) begin
        if (!reset_n) tx_credit <= 1'b0;
        else if (slow_credit) tx_credit <= (rand_bits(3) == 16'd0);
        else tx_credit <= tx_dv;  // hand back one credit per byte
    end

    // reply checker
    always @(posedge clk) begin
        if (reset_n) begin
            if (tx_credit) granted++;
            if (tx_dv) begin
                sent++;
                if (exp_q.size() == 0) begin
                    $display("unexpected reply byte %h at %0t", tx_byte, $time);
                    errors++;
                end else begin
                    exp_item = exp_q.pop_front();
                    check_byte("o_tx_byte", tx_byte, exp_item.data);
                    check_last(tx_last, exp_item.last);
                end
            end
            if (sent > granted + `DBG_LINK_CREDITS) begin
                $display("more bytes sent than link credits granted at %0t", $time);
                errors++;
            end
        end
    end

    initial begin
        byte_q_t     cmd;
        logic [15:0] base;
        logic [15:0] base_slow;
        clk             = 1'b0;
        reset_n         = 1'b0;
        rx_dv           = 1'b0;
        rx_byte         = 8'h00;
        tx_credit       = 1'b0;
        slow_credit     = 1'b0;
        lfsr            = 16'd2;
        errors          = 0;
        err_mark        = 0;
        tests           = 0;
        sent            = 0;
        granted         = 0;
        model_ctrl      = 8'h00;
        model_cmd_count = 8'h00;
        model_bad_count = 8'h00;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);

        if (tx_dv !== 1'b0) begin
            $display("error at %0t: o_tx_dv got %b expected 0", $time, tx_dv);
            errors++;
        end
        check_cmd(debug_cmd, dbg_proto_pkg::CMD_NOP);
        check_count("o_debug_bytes_remaining", debug_remaining, 16'd0);
        cmd = {dbg_proto_pkg::CMD_ECHO, 8'(rand_bits(8))};
        run_cmd(cmd, 1'b0);
        end_test("reset values and echo");

        base = rand_bits(16);
        run_cmd(build_mem_cmd(dbg_proto_pkg::CMD_MEM_WRITE, base, 16'd20, 1'b1), 1'b1);
        run_cmd(build_mem_cmd(dbg_proto_pkg::CMD_MEM_READ, base, 16'd20, 1'b0), 1'b1);
        end_test("burst write and read back");

        base_slow = base + 16'd100;
        run_cmd(build_mem_cmd(dbg_proto_pkg::CMD_MEM_WRITE, base_slow, 16'd40, 1'b1), 1'b0);
        @(negedge clk);
        slow_credit = 1'b1;
        run_cmd(build_mem_cmd(dbg_proto_pkg::CMD_MEM_READ, base_slow, 16'd40, 1'b0), 1'b0);
        wait_link_credit(3000);
        @(negedge clk);
        slow_credit = 1'b0;
        end_test("long read under slow link credit");

        cmd = {dbg_proto_pkg::CMD_REG_WRITE, dbg_proto_pkg::REG_CTRL, 8'h01};
        run_cmd(cmd, 1'b0);
        run_cmd(build_mem_cmd(dbg_proto_pkg::CMD_MEM_WRITE, base, 16'd20, 1'b1), 1'b1);
        run_cmd(build_mem_cmd(dbg_proto_pkg::CMD_MEM_READ, base, 16'd20, 1'b0), 1'b0);
        cmd = {dbg_proto_pkg::CMD_REG_WRITE, dbg_proto_pkg::REG_CTRL, 8'h00};
        run_cmd(cmd, 1'b0);
        run_cmd(build_mem_cmd(dbg_proto_pkg::CMD_MEM_WRITE, base, 16'd20, 1'b1), 1'b1);
        run_cmd(build_mem_cmd(dbg_proto_pkg::CMD_MEM_READ, base, 16'd20, 1'b0), 1'b0);
        end_test("write protect");

        repeat (3) begin
            cmd.delete();
            cmd.push_back(8'd6 + 8'(rand_bits(7)));  // 6 and up are undefined
            run_cmd(cmd, 1'b0);
        end
        cmd = {dbg_proto_pkg::CMD_REG_READ, dbg_proto_pkg::REG_BAD_OPCODE};
        run_cmd(cmd, 1'b0);
        cmd = {dbg_proto_pkg::CMD_REG_READ, dbg_proto_pkg::REG_CMD_COUNT};
        run_cmd(cmd, 1'b0);
        end_test("unknown opcodes and counters");

        run_cmd(build_mem_cmd(dbg_proto_pkg::CMD_MEM_READ, base, 16'd0, 1'b0), 1'b0);
        cmd = {dbg_proto_pkg::CMD_ECHO, 8'(rand_bits(8))};
        run_cmd(cmd, 1'b0);
        end_test("zero length read then echo");

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== common/dbg_macros.svh ====
`ifndef DBG_MACROS_SVH
`define DBG_MACROS_SVH

// address bits actually decoded by the target RAM
`define DBG_MEM_AW       10
`define DBG_MEM_DEPTH    1024

`define DBG_RX_DEPTH     16
`define DBG_TX_DEPTH     8   // also the engine's starting credit

// credit granted by the downstream consumer out of reset
`define DBG_LINK_CREDITS 4

`endif

// ==== common/dbg_mem_pkg.sv ====
package dbg_mem_pkg;

    typedef logic [15:0] mem_addr_t;
    typedef logic [7:0]  mem_data_t;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

endpackage

// ==== common/dbg_proto_pkg.sv ====
package dbg_proto_pkg;

    // opcodes, first byte of every command
    typedef enum logic [7:0] {
        CMD_NOP       = 8'd0,
        CMD_ECHO      = 8'd1,  // one byte in, same byte out
        CMD_MEM_WRITE = 8'd2,  // addr hi, addr lo, len hi, len lo, data
        CMD_MEM_READ  = 8'd3,  // addr hi, addr lo, len hi, len lo
        CMD_REG_WRITE = 8'd4,  // reg addr, value
        CMD_REG_READ  = 8'd5   // reg addr
    } dbg_cmd_e;

    // control and status register map
    typedef enum logic [7:0] {
        REG_CTRL        = 8'd0,  // bit 0 is write protect
        REG_CMD_COUNT   = 8'd1,
        REG_BAD_OPCODE  = 8'd2,
        REG_RX_OVERFLOW = 8'd3
    } dbg_reg_e;

    // one reply byte on its way to the link
    typedef struct packed {
        logic [7:0] data;
        logic       last;  // final byte of a reply
    } tx_item_t;

endpackage

// ==== compile.f ====
+incdir+common
common/dbg_proto_pkg.sv
common/dbg_mem_pkg.sv
hw/dbg_byte_queue.sv
hw/dbg_target_ram.sv
debugger/dbg_ctrl_regs.sv
debugger/dbg_cmd_engine.sv
hw/dbg_top.sv
bench/dbg_sva.sv
bench/dbg_tb.sv

// ==== debugger/dbg_cmd_engine.sv ====
`timescale 1ns/1ps
`include "dbg_macros.svh"

module dbg_cmd_engine (
    input  logic                     i_clk,
    input  logic                     i_reset_n,

    input  logic                     i_rxq_valid,
    input  logic [7:0]               i_rxq_byte,
    output logic                     o_rxq_pop,

    output logic                     o_txq_push,
    output dbg_proto_pkg::tx_item_t  o_txq_item,
    input  logic                     i_txq_credit_ret,

    output logic                     o_mem_en,
    output dbg_mem_pkg::mem_op_e     o_mem_op,
    output dbg_mem_pkg::mem_addr_t   o_mem_addr,
    output dbg_mem_pkg::mem_data_t   o_mem_wdata,
    input  dbg_mem_pkg::mem_data_t   i_mem_rdata,

    output logic                     o_reg_wr_en,
    output dbg_proto_pkg::dbg_reg_e  o_reg_addr,
    output logic [7:0]               o_reg_wdata,
    input  logic [7:0]               i_reg_rdata,
    input  logic                     i_write_protect,

    output logic                     o_cmd_done,
    output logic                     o_bad_opcode,

    output dbg_proto_pkg::dbg_cmd_e  o_debug_cmd,
    output logic [15:0]              o_debug_bytes_remaining
);

    localparam int CW = $clog2(`DBG_TX_DEPTH + 1);
    localparam logic [2:0] IDX_DATA = 3'd4;  // header done, payload phase

    dbg_proto_pkg::dbg_cmd_e  cmd;
    dbg_proto_pkg::tx_item_t  item_r;
    dbg_mem_pkg::mem_addr_t   addr;          // next address of the burst
    logic [2:0]               idx;
    logic [15:0]              remaining;
    logic [7:0]               len_hi;
    logic [CW-1:0]            credit;        // free slots in the transmit queue
    logic                     take;
    logic                     rd_issue;
    logic                     spend;
    logic                     finish;
    logic                     rd_last;
    logic                     rd_pend;
    logic                     rd_pend_last;
    logic                     reg_rd_q;
    logic                     push_r;

    // whether the current command can accept another byte
    always_comb begin
        case (cmd)
            dbg_proto_pkg::CMD_NOP:      take = 1'b1;
            dbg_proto_pkg::CMD_ECHO,
            dbg_proto_pkg::CMD_REG_READ: take = (remaining != 0) && (credit != 0);
            dbg_proto_pkg::CMD_MEM_READ: take = (remaining != 0) && (idx != IDX_DATA);
            default:                     take = (remaining != 0);
        endcase
    end

    assign o_rxq_pop = i_rxq_valid && take;

    // a read goes out only with a reply slot already reserved
    assign rd_issue = (cmd == dbg_proto_pkg::CMD_MEM_READ) && (idx == IDX_DATA)
                      && (remaining != 0) && (credit != 0);
    assign spend = rd_issue || (o_rxq_pop && (cmd == dbg_proto_pkg::CMD_ECHO ||
                                              cmd == dbg_proto_pkg::CMD_REG_READ));

    assign finish = (cmd != dbg_proto_pkg::CMD_NOP) && (remaining == 0)
                    && !o_mem_en && !rd_pend && !reg_rd_q;

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            cmd          <= dbg_proto_pkg::CMD_NOP;
            idx          <= '0;
            remaining    <= '0;
            len_hi       <= '0;
            addr         <= '0;
            credit       <= CW'(`DBG_TX_DEPTH);
            o_mem_en     <= 1'b0;
            o_mem_op     <= dbg_mem_pkg::MEM_READ;
            o_mem_addr   <= '0;
            o_mem_wdata  <= '0;
            o_reg_wr_en  <= 1'b0;
            o_reg_addr   <= dbg_proto_pkg::REG_CTRL;
            o_reg_wdata  <= '0;
            o_cmd_done   <= 1'b0;
            o_bad_opcode <= 1'b0;
            push_r       <= 1'b0;
            item_r       <= '0;
            rd_last      <= 1'b0;
            rd_pend      <= 1'b0;
            rd_pend_last <= 1'b0;
            reg_rd_q     <= 1'b0;
        end else begin
            o_mem_en     <= 1'b0;
            o_reg_wr_en  <= 1'b0;
            o_cmd_done   <= 1'b0;
            o_bad_opcode <= 1'b0;
            push_r       <= 1'b0;
            reg_rd_q     <= 1'b0;
            credit       <= credit - CW'(spend) + CW'(i_txq_credit_ret);

            // RAM data shows up one cycle after the enable
            rd_pend      <= o_mem_en && (o_mem_op == dbg_mem_pkg::MEM_READ);
            rd_pend_last <= rd_last;

            if (reg_rd_q) begin
                push_r <= 1'b1;  // register value is valid now
                item_r <= '{data: i_reg_rdata, last: 1'b1};
            end

            if (rd_issue) begin
                o_mem_en   <= 1'b1;
                o_mem_op   <= dbg_mem_pkg::MEM_READ;
                o_mem_addr <= addr;
                addr       <= addr + 16'd1;
                remaining  <= remaining - 16'd1;
                rd_last    <= (remaining == 16'd1);
            end

            if (finish) begin
                cmd        <= dbg_proto_pkg::CMD_NOP;
                o_cmd_done <= 1'b1;
            end else if (o_rxq_pop) begin
                if (cmd == dbg_proto_pkg::CMD_NOP) begin
                    idx <= '0;
                    case (i_rxq_byte)
                        dbg_proto_pkg::CMD_NOP: o_cmd_done <= 1'b1;
                        dbg_proto_pkg::CMD_ECHO,
                        dbg_proto_pkg::CMD_REG_READ: begin
                            cmd       <= dbg_proto_pkg::dbg_cmd_e'(i_rxq_byte);
                            remaining <= 16'd1;
                        end
                        dbg_proto_pkg::CMD_REG_WRITE: begin
                            cmd       <= dbg_proto_pkg::CMD_REG_WRITE;
                            remaining <= 16'd2;
                        end
                        dbg_proto_pkg::CMD_MEM_WRITE,
                        dbg_proto_pkg::CMD_MEM_READ: begin
                            cmd       <= dbg_proto_pkg::dbg_cmd_e'(i_rxq_byte);
                            remaining <= 16'd4;  // header only for now
                        end
                        default: o_bad_opcode <= 1'b1;  // single byte, dropped
                    endcase
                end else begin
                    if (idx != IDX_DATA) begin
                        idx <= idx + 3'd1;
                    end
                    remaining <= remaining - 16'd1;
                    case (cmd)
                        dbg_proto_pkg::CMD_ECHO: begin
                            push_r <= 1'b1;
                            item_r <= '{data: i_rxq_byte, last: 1'b1};
                        end
                        dbg_proto_pkg::CMD_REG_READ: begin
                            o_reg_addr <= dbg_proto_pkg::dbg_reg_e'(i_rxq_byte);
                            reg_rd_q   <= 1'b1;
                        end
                        dbg_proto_pkg::CMD_REG_WRITE: begin
                            if (idx == 3'd0) begin
                                o_reg_addr <= dbg_proto_pkg::dbg_reg_e'(i_rxq_byte);
                            end else begin
                                o_reg_wr_en <= 1'b1;
                                o_reg_wdata <= i_rxq_byte;
                            end
                        end
                        default: begin
                            // memory commands share the header layout
                            case (idx)
                                3'd0: addr[15:8] <= i_rxq_byte;
                                3'd1: addr[7:0]  <= i_rxq_byte;
                                3'd2: len_hi     <= i_rxq_byte;
                                3'd3: remaining  <= {len_hi, i_rxq_byte};
                                default: begin
                                    // data still consumed when protected
                                    if (!i_write_protect) begin
                                        o_mem_en    <= 1'b1;
                                        o_mem_op    <= dbg_mem_pkg::MEM_WRITE;
                                        o_mem_addr  <= addr;
                                        o_mem_wdata <= i_rxq_byte;
                                    end
                                    addr <= addr + 16'd1;
                                end
                            endcase
                        end
                    endcase
                end
            end
        end
    end

    // read data bypasses the reply register so it leaves right away
    assign o_txq_push = push_r || rd_pend;
    assign o_txq_item = rd_pend ? dbg_proto_pkg::tx_item_t'{data: i_mem_rdata,
                                                            last: rd_pend_last}
                                : item_r;

    assign o_debug_cmd             = cmd;
    assign o_debug_bytes_remaining = remaining;

endmodule

// ==== debugger/dbg_ctrl_regs.sv ====
`timescale 1ns/1ps

module dbg_ctrl_regs (
    input  logic                     i_clk,
    input  logic                     i_reset_n,
    input  logic                     i_wr_en,
    input  dbg_proto_pkg::dbg_reg_e  i_addr,
    input  logic [7:0]               i_wdata,
    output logic [7:0]               o_rdata,
    input  logic                     i_cmd_done,
    input  logic                     i_bad_opcode,
    input  logic                     i_rx_overflow,
    output logic                     o_write_protect
);

    logic [7:0] ctrl;
    logic [7:0] cmd_count;
    logic [7:0] bad_count;
    logic [7:0] ovf_count;

    // counters stick at 255, any write clears them
    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            ctrl      <= '0;
            cmd_count <= '0;
            bad_count <= '0;
            ovf_count <= '0;
        end else begin
            if (i_wr_en && i_addr == dbg_proto_pkg::REG_CTRL) begin
                ctrl <= i_wdata;
            end

            if (i_wr_en && i_addr == dbg_proto_pkg::REG_CMD_COUNT) begin
                cmd_count <= '0;
            end else if (i_cmd_done && cmd_count != 8'hff) begin
                cmd_count <= cmd_count + 8'd1;
            end

            if (i_wr_en && i_addr == dbg_proto_pkg::REG_BAD_OPCODE) begin
                bad_count <= '0;
            end else if (i_bad_opcode && bad_count != 8'hff) begin
                bad_count <= bad_count + 8'd1;
            end

            if (i_wr_en && i_addr == dbg_proto_pkg::REG_RX_OVERFLOW) begin
                ovf_count <= '0;
            end else if (i_rx_overflow && ovf_count != 8'hff) begin
                ovf_count <= ovf_count + 8'd1;
            end
        end
    end

    always_comb begin
        case (i_addr)
            dbg_proto_pkg::REG_CTRL:        o_rdata = ctrl;
            dbg_proto_pkg::REG_CMD_COUNT:   o_rdata = cmd_count;
            dbg_proto_pkg::REG_BAD_OPCODE:  o_rdata = bad_count;
            dbg_proto_pkg::REG_RX_OVERFLOW: o_rdata = ovf_count;
            default:                        o_rdata = 8'h00;  // unmapped
        endcase
    end

    assign o_write_protect = ctrl[0];

endmodule

// ==== hw/dbg_byte_queue.sv ====
`timescale 1ns/1ps

module dbg_byte_queue #(
    parameter type item_t       = logic [7:0],
    parameter int  DEPTH        = 16,
    parameter int  LINK_CREDITS = 0
) (
    input  logic   i_clk,
    input  logic   i_reset_n,
    input  logic   i_push,
    input  item_t  i_item,
    output logic   o_full,
    output logic   o_credit_ret,
    input  logic   i_credit,
    output logic   o_valid,
    output item_t  o_item,
    input  logic   i_pop
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    item_t          mem [DEPTH];
    logic [PW-1:0]  wr_ptr;
    logic [PW-1:0]  rd_ptr;
    logic [CW-1:0]  count;
    logic           do_push;
    logic           do_pop;

    assign o_full       = (count == CW'(DEPTH));
    assign do_push      = i_push && !o_full;  // a push into a full queue is lost
    assign o_credit_ret = do_pop;

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_item;
        end
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + PW'(1);
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + PW'(1);
            end
            count <= count + CW'(do_push) - CW'(do_pop);
        end
    end

    if (LINK_CREDITS != 0) begin : g_link
        logic [15:0] link_credit;
        logic        valid_q;
        item_t       item_q;

        // sends on its own while the consumer has granted room
        assign do_pop = (count != 0) && (link_credit != 0);

        always_ff @(posedge i_clk or negedge i_reset_n) begin
            if (!i_reset_n) begin
                link_credit <= 16'(LINK_CREDITS);
                valid_q     <= 1'b0;
            end else begin
                link_credit <= link_credit + 16'(i_credit) - 16'(do_pop);
                valid_q     <= do_pop;  // one-cycle send strobe
            end
        end

        always_ff @(posedge i_clk) begin
            if (do_pop) begin
                item_q <= mem[rd_ptr];
            end
        end

        assign o_valid = valid_q;
        assign o_item  = item_q;
    end else begin : g_direct
        assign do_pop  = i_pop && (count != 0);
        assign o_valid = (count != 0);
        assign o_item  = mem[rd_ptr];  // head of queue, first word fall through
    end

endmodule

// ==== hw/dbg_target_ram.sv ====
`timescale 1ns/1ps
`include "dbg_macros.svh"

module dbg_target_ram (
    input  logic                    i_clk,
    input  logic                    i_en,
    input  dbg_mem_pkg::mem_op_e    i_op,
    input  dbg_mem_pkg::mem_addr_t  i_addr,
    input  dbg_mem_pkg::mem_data_t  i_wdata,
    output dbg_mem_pkg::mem_data_t  o_rdata
);

    dbg_mem_pkg::mem_data_t mem [`DBG_MEM_DEPTH];

    // upper address bits fold onto the decoded range
    always_ff @(posedge i_clk) begin
        if (i_en) begin
            if (i_op == dbg_mem_pkg::MEM_WRITE) begin
                mem[i_addr[`DBG_MEM_AW-1:0]] <= i_wdata;
            end else begin
                o_rdata <= mem[i_addr[`DBG_MEM_AW-1:0]];  // one cycle latency
            end
        end
    end

endmodule

// ==== hw/dbg_top.sv ====
`timescale 1ns/1ps
`include "dbg_macros.svh"

module dbg_top (
    input  logic                     i_clk,
    input  logic                     i_reset_n,
    input  logic                     i_rx_dv,
    input  logic [7:0]               i_rx_byte,
    input  logic                     i_tx_credit,
    output logic                     o_tx_dv,
    output logic [7:0]               o_tx_byte,
    output logic                     o_tx_last,
    output dbg_proto_pkg::dbg_cmd_e  o_debug_cmd,
    output logic [15:0]              o_debug_bytes_remaining
);

    logic                     rxq_full;
    logic                     rxq_valid;
    logic [7:0]               rxq_byte;
    logic                     rxq_pop;
    logic                     rx_overflow;

    logic                     txq_push;
    dbg_proto_pkg::tx_item_t  txq_item;
    logic                     txq_credit_ret;
    dbg_proto_pkg::tx_item_t  tx_out;

    logic                     mem_en;
    dbg_mem_pkg::mem_op_e     mem_op;
    dbg_mem_pkg::mem_addr_t   mem_addr;
    dbg_mem_pkg::mem_data_t   mem_wdata;
    dbg_mem_pkg::mem_data_t   mem_rdata;

    logic                     reg_wr_en;
    dbg_proto_pkg::dbg_reg_e  reg_addr;
    logic [7:0]               reg_wdata;
    logic [7:0]               reg_rdata;
    logic                     write_protect;
    logic                     cmd_done;
    logic                     bad_opcode;

    assign rx_overflow = i_rx_dv && rxq_full;  // sender cannot be stalled

    dbg_byte_queue #(
        .item_t       (logic [7:0]),
        .DEPTH        (`DBG_RX_DEPTH),
        .LINK_CREDITS (0)
    ) i_rx_queue (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_push       (i_rx_dv),
        .i_item       (i_rx_byte),
        .o_full       (rxq_full),
        .o_credit_ret (),
        .i_credit     (1'b0),
        .o_valid      (rxq_valid),
        .o_item       (rxq_byte),
        .i_pop        (rxq_pop)
    );

    dbg_cmd_engine i_cmd_engine (
        .i_clk                   (i_clk),
        .i_reset_n               (i_reset_n),
        .i_rxq_valid             (rxq_valid),
        .i_rxq_byte              (rxq_byte),
        .o_rxq_pop               (rxq_pop),
        .o_txq_push              (txq_push),
        .o_txq_item              (txq_item),
        .i_txq_credit_ret        (txq_credit_ret),
        .o_mem_en                (mem_en),
        .o_mem_op                (mem_op),
        .o_mem_addr              (mem_addr),
        .o_mem_wdata             (mem_wdata),
        .i_mem_rdata             (mem_rdata),
        .o_reg_wr_en             (reg_wr_en),
        .o_reg_addr              (reg_addr),
        .o_reg_wdata             (reg_wdata),
        .i_reg_rdata             (reg_rdata),
        .i_write_protect         (write_protect),
        .o_cmd_done              (cmd_done),
        .o_bad_opcode            (bad_opcode),
        .o_debug_cmd             (o_debug_cmd),
        .o_debug_bytes_remaining (o_debug_bytes_remaining)
    );

    dbg_ctrl_regs i_ctrl_regs (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_wr_en         (reg_wr_en),
        .i_addr          (reg_addr),
        .i_wdata         (reg_wdata),
        .o_rdata         (reg_rdata),
        .i_cmd_done      (cmd_done),
        .i_bad_opcode    (bad_opcode),
        .i_rx_overflow   (rx_overflow),
        .o_write_protect (write_protect)
    );

    dbg_target_ram i_target_ram (
        .i_clk   (i_clk),
        .i_en    (mem_en),
        .i_op    (mem_op),
        .i_addr  (mem_addr),
        .i_wdata (mem_wdata),
        .o_rdata (mem_rdata)
    );

    // never fills, the engine only pushes against its credits
    dbg_byte_queue #(
        .item_t       (dbg_proto_pkg::tx_item_t),
        .DEPTH        (`DBG_TX_DEPTH),
        .LINK_CREDITS (`DBG_LINK_CREDITS)
    ) i_tx_queue (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_push       (txq_push),
        .i_item       (txq_item),
        .o_full       (),
        .o_credit_ret (txq_credit_ret),
        .i_credit     (i_tx_credit),
        .o_valid      (o_tx_dv),
        .o_item       (tx_out),
        .i_pop        (1'b0)
    );

    assign o_tx_byte = tx_out.data;
    assign o_tx_last = tx_out.last;

endmodule
